/* tb.f */
+incdir+rtl
rtl/exu_op_pkg.sv
rtl/exu_bus_pkg.sv
rtl/exu_operand.sv
rtl/exu_alu.sv
rtl/exu_mul.sv
rtl/exu_retire.sv
rtl/exu_top.sv
verif/exu_properties.sv
verif/tb_exu_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_exu_top
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation did not finish"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/tb_exu_top.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module tb_exu_top
    import exu_op_pkg::*;
    import exu_bus_pkg::*;
;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    exu_req_t             req;
    logic                 in_valid;
    logic                 in_ready;
    logic [`EXU_XLEN-1:0] res;
    logic                 out_valid;

    logic [31:0] lfsr = 32'h79b9bcd7;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          local_errs = 0;
    int          errs_before;

    exu_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req       (req),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .res       (res),
        .out_valid (out_valid)
    );

    always #20 clk = ~clk;

    // taps 32 22 2 1, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic exu_req_t make_req(input logic [4:0] op, input logic [1:0] sa,
                                         input logic [1:0] sb, input logic w);
        exu_req_t r;
        r.op    = exu_op_e'(op);
        r.sel_a = exu_sel_a_e'(sa);
        r.sel_b = exu_sel_b_e'(sb);
        r.word  = w;
        r.pc    = rand_bits(64);
        r.rs1   = rand_bits(64);
        r.rs2   = rand_bits(64);
        r.csr   = rand_bits(64);
        r.imm   = rand_bits(64);
        return r;
    endfunction

    task automatic send(input exu_req_t r);
        int n;
        n = 0;
        req      = r;
        in_valid = 1'b1;
        while (!in_ready && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            $display("timeout: in_ready never came back at %0t", $time);
            local_errs++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_out(input int limit);
        int n;
        n = 0;
        while (!out_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            $display("timeout: no result within %0d cycles at %0t", limit, $time);
            local_errs++;
        end
        @(negedge clk);
    endtask

    task automatic begin_test();
        errs_before = u_dut.u_props.err_count + local_errs;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = u_dut.u_props.err_count + local_errs - errs_before;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
            $display("mismatch at %0t: test %s saw %0d failures", $time, name, errs);
        end else begin
            $display("test %s done", name);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        req = '0;
        begin_test();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (4) @(negedge clk);
        end_test("reset");

        begin_test();
        for (int c = 0; c < 32; c++) begin
            send(make_req(5'(rand_bits(4) % 15), c[4:3], c[2:1], c[0]));
            wait_out(5);
        end
        end_test("single_ops");

        begin_test();
        for (int i = 0; i < 20; i++) begin
            req      = make_req(5'(rand_bits(4) % 15), 2'(rand_bits(2)), 2'(rand_bits(2)),
                                1'(rand_bits(1)));
            in_valid = 1'b1;
            @(negedge clk);
        end
        in_valid = 1'b0;
        wait_out(5);
        // the last result lands one cycle after the one seen above
        @(negedge clk);
        end_test("back_to_back");

        begin_test();
        for (int i = 0; i < 11; i++) begin
            req = make_req(OP_MUL, SEL_A_RS1, SEL_B_RS2, 1'b0);
            // special multipliers come last
            if (i == 8) req.rs2 = '0;
            if (i == 9) req.rs2 = 64'd1;
            if (i == 10) req.rs2 = '1;
            send(req);
            wait_out(80);
        end
        end_test("multiply");

        begin_test();
        req = make_req(OP_MUL, SEL_A_RS1, SEL_B_RS2, 1'b0);
        req.rs2 = '1;
        send(req);
        repeat (5) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (70) begin
            @(negedge clk);
            if (out_valid) begin
                $display("flushed multiply still produced a result at %0t", $time);
                local_errs++;
            end
        end
        end_test("flush");

        begin_test();
        for (int op = 16; op < 32; op++) begin
            send(make_req(5'(op), 2'(rand_bits(2)), 2'(rand_bits(2)), 1'(rand_bits(1))));
            wait_out(5);
        end
        end_test("unused_ops");

        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0 && u_dut.u_props.err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verif/exu_properties.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_properties
    import exu_op_pkg::*;
    import exu_bus_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 flush,
    input exu_req_t             req,
    input logic                 in_valid,
    input logic                 in_ready,
    input logic [`EXU_XLEN-1:0] res,
    input logic                 out_valid
);

    int                   err_count = 0;
    logic                 accept;
    logic [`EXU_XLEN-1:0] opa;
    logic [`EXU_XLEN-1:0] opb;
    logic                 alu_exp1_v;
    logic                 alu_exp2_v;
    logic [`EXU_XLEN-1:0] alu_exp1;
    logic [`EXU_XLEN-1:0] alu_exp2;
    logic                 mul_pend;
    logic                 mul_done;
    logic [`EXU_XLEN-1:0] mul_exp;
    int                   mul_cnt;

    // reference model of the single-cycle rules
    function automatic logic [`EXU_XLEN-1:0] model(input logic [4:0] op, input logic word,
                                                  input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        logic [31:0] lo;
        int          sh;
        sh = int'(b[5:0]);
        r  = 64'd0;
        case (op)
            5'd0:  r = a + b;
            5'd1:  r = a + ~b + 64'd1;
            5'd2:  r = a;
            5'd3:  r = b;
            5'd4:  r = a ^ b;
            5'd5:  r = a | b;
            5'd6:  r = a & b;
            5'd7:  r = a << sh;
            5'd8:  r = a >> sh;
            5'd9: begin
                if (word) begin
                    lo = 32'($signed(a[31:0]) >>> sh);
                    r  = {32'd0, lo};
                end else begin
                    r = $signed(a) >>> sh;
                end
            end
            5'd10: r = {63'd0, $signed(a) < $signed(b)};
            5'd11: r = {63'd0, a < b};
            5'd12: r = {63'd0, a == b};
            5'd13: r = {63'd0, !($signed(a) < $signed(b))};
            5'd14: r = {63'd0, !(a < b)};
            default: r = 64'd0;
        endcase
        return r;
    endfunction

    assign accept = in_valid & in_ready;
    assign opa = (req.sel_a == 2'd1) ? (req.word ? {32'd0, req.rs1[31:0]} : req.rs1) : req.pc;
    assign opb = (req.sel_b == 2'd1) ? req.rs2 : (req.sel_b == 2'd2) ? req.csr : req.imm;

    // a result that no alu op accounts for belongs to the multiply
    assign mul_done = mul_pend && out_valid && !alu_exp2_v;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_exp1_v <= 1'b0;
            alu_exp2_v <= 1'b0;
            mul_pend   <= 1'b0;
            mul_cnt    <= 0;
        end else begin
            alu_exp1_v <= accept && (req.op != OP_MUL);
            alu_exp1   <= model(req.op, req.word, opa, opb);
            alu_exp2_v <= alu_exp1_v;
            alu_exp2   <= alu_exp1;
            if (accept && req.op == OP_MUL) begin
                mul_pend <= 1'b1;
                mul_exp  <= opa * opb;
                mul_cnt  <= 0;
            end else if (flush || mul_done) begin
                mul_pend <= 1'b0;
            end else if (mul_pend) begin
                mul_cnt <= mul_cnt + 1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) rst |=> (!out_valid && in_ready))
        else begin
            $error("outputs not idle after reset");
            err_count++;
        end

    a_alu_result: assert property (@(posedge clk) disable iff (rst)
        alu_exp2_v |-> (out_valid && res == alu_exp2))
        else begin
            $error("alu result missing or wrong");
            err_count++;
        end

    a_no_stray: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (alu_exp2_v || mul_pend))
        else begin
            $error("unexpected out_valid");
            err_count++;
        end

    a_mul_result: assert property (@(posedge clk) disable iff (rst)
        mul_done |-> (res == mul_exp))
        else begin
            $error("multiply result wrong");
            err_count++;
        end

    a_mul_stall: assert property (@(posedge clk) disable iff (rst)
        (mul_pend && !mul_done) |-> !in_ready)
        else begin
            $error("in_ready high during multiply");
            err_count++;
        end

    a_ready_idle: assert property (@(posedge clk) disable iff (rst)
        !mul_pend |-> in_ready)
        else begin
            $error("in_ready low while idle");
            err_count++;
        end

    // start pulse plus at most one step per multiplier bit and the final register
    a_mul_bound: assert property (@(posedge clk) disable iff (rst)
        mul_pend |-> (mul_cnt <= `EXU_MUL_MAX + 2))
        else begin
            $error("multiply took too long");
            err_count++;
        end

endmodule

bind exu_top exu_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .req       (req),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .res       (res),
    .out_valid (out_valid)
);

/* rtl/exu_top.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_top
    import exu_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  exu_req_t             req,
    input  logic                 in_valid,
    output logic                 in_ready,
    output logic [`EXU_XLEN-1:0] res,
    output logic                 out_valid
);

    exu_opnd_t            alu_issue;
    logic                 mul_start;
    logic [`EXU_XLEN-1:0] mul_a;
    logic [`EXU_XLEN-1:0] mul_b;
    exu_res_t             alu_res;
    exu_res_t             mul_res;
    logic                 busy;

    exu_operand u_operand (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .busy      (busy),
        .alu_issue (alu_issue),
        .mul_start (mul_start),
        .mul_a     (mul_a),
        .mul_b     (mul_b)
    );

    exu_alu u_alu (
        .clk       (clk),
        .rst       (rst),
        .alu_issue (alu_issue),
        .alu_res   (alu_res)
    );

    exu_mul u_mul (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .mul_start (mul_start),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .mul_res   (mul_res)
    );

    exu_retire u_retire (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .mul_start (mul_start),
        .alu_res   (alu_res),
        .mul_res   (mul_res),
        .busy      (busy),
        .res       (res),
        .out_valid (out_valid)
    );

endmodule

/* rtl/exu_retire.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_retire
    import exu_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 mul_start,
    input  exu_res_t             alu_res,
    input  exu_res_t             mul_res,
    output logic                 busy,
    output logic [`EXU_XLEN-1:0] res,
    output logic                 out_valid
);

    logic busy_q;

    // a multiply is in flight from start until its result shows up
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (flush) begin
            busy_q <= 1'b0;
        end else if (mul_start) begin
            busy_q <= 1'b1;
        end else if (mul_res.valid) begin
            busy_q <= 1'b0;
        end
    end

    // drop busy together with the result so in_ready returns with it
    assign busy = busy_q & ~mul_res.valid;

    // the two sources never hold a valid result in the same cycle
    assign out_valid = alu_res.valid | mul_res.valid;
    assign res       = mul_res.valid ? mul_res.data : alu_res.data;

endmodule

/* rtl/exu_mul.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_mul
    import exu_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 mul_start,
    input  logic [`EXU_XLEN-1:0] mul_a,
    input  logic [`EXU_XLEN-1:0] mul_b,
    output exu_res_t             mul_res
);

    logic                 active;
    logic                 finish;
    logic [`EXU_XLEN-1:0] mcand;
    logic [`EXU_XLEN-1:0] mplier;
    logic [`EXU_XLEN-1:0] acc;
    logic                 res_valid;
    logic [`EXU_XLEN-1:0] res_data;

    // done once no multiplier bits remain
    assign finish = active && (mplier == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (flush) begin
                active <= 1'b0;
            end else if (mul_start) begin
                active <= 1'b1;
            end else if (finish) begin
                active    <= 1'b0;
                res_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand  <= mul_a;
            mplier <= mul_b;
            acc    <= '0;
        end else if (active && !finish) begin
            // one multiplier bit per step, low bit first
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            res_data <= acc;
        end
    end

    assign mul_res = '{valid: res_valid, data: res_data};

endmodule

/* rtl/exu_alu.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_alu
    import exu_op_pkg::*;
    import exu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  exu_opnd_t alu_issue,
    output exu_res_t  alu_res
);

    logic [`EXU_XLEN-1:0]        a;
    logic [`EXU_XLEN-1:0]        b;
    logic [5:0]                  shamt;
    logic signed [31:0]          sra_word;
    logic signed [`EXU_XLEN-1:0] sra_dword;
    logic [`EXU_XLEN-1:0]        result;
    logic                        res_valid;
    logic [`EXU_XLEN-1:0]        res_data;

    assign a     = alu_issue.a;
    assign b     = alu_issue.b;
    assign shamt = b[5:0];

    // word sra shifts the low half signed, upper half zero
    assign sra_word  = $signed(a[31:0]) >>> shamt;
    assign sra_dword = $signed(a) >>> shamt;

    always_comb begin
        case (alu_issue.op)
            OP_ADD:    result = a + b;
            OP_SUB:    result = a - b;
            OP_PASS_A: result = a;
            OP_PASS_B: result = b;
            OP_XOR:    result = a ^ b;
            OP_OR:     result = a | b;
            OP_AND:    result = a & b;
            OP_SLL:    result = a << shamt;
            OP_SRL:    result = a >> shamt;
            OP_SRA: begin
                if (alu_issue.word) begin
                    result = {32'b0, sra_word};
                end else begin
                    result = sra_dword;
                end
            end
            OP_SLT:    result = {63'b0, $signed(a) < $signed(b)};
            OP_SLTU:   result = {63'b0, a < b};
            OP_EQ:     result = {63'b0, a == b};
            OP_GE:     result = {63'b0, $signed(a) >= $signed(b)};
            OP_GEU:    result = {63'b0, a >= b};
            // mul never reaches here, unused codes read as zero
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= alu_issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue.valid) begin
            res_data <= result;
        end
    end

    assign alu_res = '{valid: res_valid, data: res_data};

endmodule

/* rtl/exu_operand.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_operand
    import exu_op_pkg::*;
    import exu_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  exu_req_t             req,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic                 busy,
    output exu_opnd_t            alu_issue,
    output logic                 mul_start,
    output logic [`EXU_XLEN-1:0] mul_a,
    output logic [`EXU_XLEN-1:0] mul_b
);

    logic                 accept;
    logic                 is_mul;
    logic                 issue_valid;
    logic [`EXU_XLEN-1:0] a;
    logic [`EXU_XLEN-1:0] b;
    exu_op_e              op_q;
    logic                 word_q;
    logic [`EXU_XLEN-1:0] a_q;
    logic [`EXU_XLEN-1:0] b_q;

    // word ops see rs1 zero-extended from bit 31
    assign a = (req.sel_a == SEL_A_RS1) ? (req.word ? {32'b0, req.rs1[31:0]} : req.rs1)
                                        : req.pc;
    assign b = (req.sel_b == SEL_B_RS2) ? req.rs2 :
               (req.sel_b == SEL_B_CSR) ? req.csr : req.imm;

    // also hold off while the start pulse is still on its way to busy
    assign in_ready = ~(busy | mul_start);
    assign accept   = in_valid & in_ready;
    assign is_mul   = (req.op == OP_MUL);

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
            mul_start   <= 1'b0;
        end else begin
            issue_valid <= accept & ~is_mul;
            mul_start   <= accept & is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= req.op;
            word_q <= req.word;
            a_q    <= a;
            b_q    <= b;
        end
    end

    assign alu_issue = '{valid: issue_valid, op: op_q, word: word_q, a: a_q, b: b_q};
    assign mul_a     = a_q;
    assign mul_b     = b_q;

endmodule

/* rtl/exu_bus_pkg.sv */
`include "exu_defs.svh"

package exu_bus_pkg;

    import exu_op_pkg::*;

    // request as presented at the stage input
    typedef struct packed {
        exu_op_e               op;
        exu_sel_a_e            sel_a;
        exu_sel_b_e            sel_b;
        logic                  word;
        logic [`EXU_XLEN-1:0]  pc;
        logic [`EXU_XLEN-1:0]  rs1;
        logic [`EXU_XLEN-1:0]  rs2;
        logic [`EXU_XLEN-1:0]  csr;
        logic [`EXU_XLEN-1:0]  imm;
    } exu_req_t;

    // operation issued to the ALU, operands already resolved
    typedef struct packed {
        logic                  valid;
        exu_op_e               op;
        logic                  word;
        logic [`EXU_XLEN-1:0]  a;
        logic [`EXU_XLEN-1:0]  b;
    } exu_opnd_t;

    typedef struct packed {
        logic                  valid;
        logic [`EXU_XLEN-1:0]  data;
    } exu_res_t;

endpackage

/* rtl/exu_op_pkg.sv */
`include "exu_defs.svh"

package exu_op_pkg;

    // codes 16..31 are unused and give a zero result
    typedef enum logic [`EXU_OP_W-1:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_PASS_A = 5'd2,
        OP_PASS_B = 5'd3,
        OP_XOR    = 5'd4,
        OP_OR     = 5'd5,
        OP_AND    = 5'd6,
        OP_SLL    = 5'd7,
        OP_SRL    = 5'd8,
        OP_SRA    = 5'd9,
        OP_SLT    = 5'd10,
        OP_SLTU   = 5'd11,
        OP_EQ     = 5'd12,
        OP_GE     = 5'd13,
        OP_GEU    = 5'd14,
        OP_MUL    = 5'd15
    } exu_op_e;

    // operand a source, codes 2 and 3 fall back to pc
    typedef enum logic [1:0] {
        SEL_A_PC  = 2'd0,
        SEL_A_RS1 = 2'd1
    } exu_sel_a_e;

    // operand b source, code 3 falls back to imm
    typedef enum logic [1:0] {
        SEL_B_IMM = 2'd0,
        SEL_B_RS2 = 2'd1,
        SEL_B_CSR = 2'd2
    } exu_sel_b_e;

endpackage

/* rtl/exu_defs.svh */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// datapath width of the integer unit
`define EXU_XLEN 64

// operation code width, room for 32 codes
`define EXU_OP_W 5

// worst-case shift-add steps for one multiply,
// one per multiplier bit
`define EXU_MUL_MAX 64

`endif
